/* common/dcache_tag_pkg.sv */
// Data cache tag package

package dcache_tag_pkg;

  //====================
  // Address geometry
  //====================

  // Physical address width
  localparam int PA_W     = 40;

  // 64-byte line
  localparam int OFFSET_W = 6;

  // 512 sets
  localparam int INDEX_W  = 9;

  // Tag is PA[39:15]
  localparam int TAG_W    = PA_W - OFFSET_W - INDEX_W;

  //====================
  // Way layout
  //====================

  // Valid bit sits above the tag
  localparam int WAY_W    = TAG_W + 1;

  // Two-way set associative
  localparam int NUM_WAYS = 2;

  // One SRAM word holds every way with way 0 in the low half
  localparam int LINE_W   = WAY_W * NUM_WAYS;

  //====================
  // Request opcodes
  //====================

  typedef enum logic [1:0] {
    OP_LOOKUP = 2'b00,
    OP_FILL   = 2'b01,
    OP_INVAL  = 2'b10
  } tag_op_e;

endpackage

/* hw/tag_array/gated_clk_cell.sv */
// Latch based clock gate
`timescale 1ns/1ps

module gated_clk_cell (
  input  logic clk_in,
  input  logic local_en,
  input  logic module_en,
  input  logic scan_en,
  output logic clk_out
);

  logic clk_en;
  logic clk_en_lat;

  // Gating disabled at module level, or local request, or scan
  assign clk_en = local_en | ~module_en | scan_en;

  // Transparent while clock low, so enable is stable over the high phase
  always_latch begin
    if (!clk_in) begin
      clk_en_lat = clk_en;
    end
  end

  // Glitch-free output
  assign clk_out = clk_in & clk_en_lat;

endmodule

/* hw/tag_array/spsram_512x52.sv */
// Single port SRAM model
`timescale 1ns/1ps

module spsram_512x52 import dcache_tag_pkg::*; (
  input  logic               clk,
  input  logic               cen_b,
  input  logic               gwen_b,
  input  logic [LINE_W-1:0]  wen_b,
  input  logic [INDEX_W-1:0] addr,
  input  logic [LINE_W-1:0]  din,
  output logic [LINE_W-1:0]  dout
);

  localparam int DEPTH = 1 << INDEX_W;

  //====================
  // Storage
  //====================

  // Contents start unknown
  logic [LINE_W-1:0] mem [DEPTH];

  //====================
  // Access
  //====================

  // Selected edge either writes or reads
  always_ff @(posedge clk) begin
    if (!cen_b) begin
      if (!gwen_b) begin
        // Keep bits whose wen_b is high
        mem[addr] <= (mem[addr] & wen_b) | (din & ~wen_b);
      end else begin
        dout <= mem[addr];
      end
    end
  end

  // dout holds across writes and idle cycles

endmodule

/* hw/tag_array/dcache_tag_array.sv */
// Data cache tag array
`timescale 1ns/1ps

module dcache_tag_array import dcache_tag_pkg::*; (
  input  logic                forever_cpuclk,
  input  logic                scan_en,
  input  logic                icg_en,
  input  logic                tag_gateclk_en,
  input  logic                tag_sel_b,
  input  logic                tag_gwen_b,
  input  logic [NUM_WAYS-1:0] tag_wen_b,
  input  logic [INDEX_W-1:0]  tag_idx,
  input  logic [LINE_W-1:0]   tag_din,
  output logic [LINE_W-1:0]   tag_dout
);

  logic              tag_clk;
  logic [LINE_W-1:0] tag_wen_b_all;

  //====================
  // Clock gate
  //====================

  // icg_en low lets the clock run free
  gated_clk_cell x_dcache_tag_gated_clk (
    .clk_in    (forever_cpuclk),
    .local_en  (tag_gateclk_en),
    .module_en (icg_en),
    .scan_en   (scan_en),
    .clk_out   (tag_clk)
  );

  //====================
  // Write mask
  //====================

  // Spread each way enable over its 26 bits
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_wen
    assign tag_wen_b_all[w*WAY_W +: WAY_W] = {WAY_W{tag_wen_b[w]}};
  end

  //====================
  // SRAM
  //====================
  spsram_512x52 x_spsram_512x52 (
    .clk    (tag_clk),
    .cen_b  (tag_sel_b),
    .gwen_b (tag_gwen_b),
    .wen_b  (tag_wen_b_all),
    .addr   (tag_idx),
    .din    (tag_din),
    .dout   (tag_dout)
  );

endmodule

/* hw/tag_req_decode.sv */
// Tag request decode
`timescale 1ns/1ps

module tag_req_decode import dcache_tag_pkg::*; (
  input  logic                forever_cpuclk,
  input  logic                rst_n,
  input  logic                req_vld,
  input  tag_op_e             req_op,
  input  logic [PA_W-1:0]     req_addr,
  input  logic [NUM_WAYS-1:0] req_way_mask,
  output logic                tag_sel_b,
  output logic                tag_gwen_b,
  output logic [NUM_WAYS-1:0] tag_wen_b,
  output logic [INDEX_W-1:0]  tag_idx,
  output logic [LINE_W-1:0]   tag_din,
  output logic                tag_gateclk_en,
  output logic                s1_vld,
  output logic [TAG_W-1:0]    s1_tag
);

  logic [TAG_W-1:0] req_tag;
  logic             req_is_lookup;
  logic             req_is_fill;
  logic             req_is_write;

  //====================
  // Address split
  //====================

  // Index sits just above the line offset
  assign tag_idx = req_addr[OFFSET_W +: INDEX_W];

  // Tag takes the remaining upper bits
  assign req_tag = req_addr[PA_W-1 -: TAG_W];

  //====================
  // Opcode decode
  //====================
  assign req_is_lookup = (req_op == OP_LOOKUP);
  assign req_is_fill   = (req_op == OP_FILL);
  assign req_is_write  = (req_op == OP_FILL) || (req_op == OP_INVAL);

  // Select on any request
  assign tag_sel_b  = ~req_vld;

  // Global write for fill and invalidate
  assign tag_gwen_b = ~(req_vld & req_is_write);

  // Per-way write enables matter only with gwen low
  assign tag_wen_b  = ~req_way_mask;

  // Clock the array only when it is accessed
  assign tag_gateclk_en = req_vld;

  // Write word is valid plus tag in each half, or all zero to invalidate
  assign tag_din = req_is_fill ? {NUM_WAYS{1'b1, req_tag}} : '0;

  //====================
  // First stage regs
  //====================

  // SRAM data lands one cycle later, so hold the lookup alongside it
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
    end else begin
      s1_vld <= req_vld & req_is_lookup;
    end
  end

  // Tag payload
  always_ff @(posedge forever_cpuclk) begin
    if (req_vld && req_is_lookup) begin
      s1_tag <= req_tag;
    end
  end

endmodule

/* hw/tag_hit_compare.sv */
// Tag hit compare
`timescale 1ns/1ps

module tag_hit_compare import dcache_tag_pkg::*; (
  input  logic              s1_vld,
  input  logic [TAG_W-1:0]  s1_tag,
  input  logic [LINE_W-1:0] tag_dout,
  output logic              cmp_vld,
  output logic              cmp_hit,
  output logic              cmp_hit_way,
  output logic              cmp_inv_found,
  output logic              cmp_inv_way
);

  logic [NUM_WAYS-1:0] way_vld;
  logic [NUM_WAYS-1:0] way_hit;

  //====================
  // Per-way check
  //====================

  // Valid is the top bit of each way entry
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    logic [WAY_W-1:0] entry;

    assign entry      = tag_dout[w*WAY_W +: WAY_W];
    assign way_vld[w] = entry[TAG_W];
    assign way_hit[w] = entry[TAG_W] && (entry[TAG_W-1:0] == s1_tag);
  end

  //====================
  // Hit select
  //====================

  // Valid comes straight from stage one
  assign cmp_vld = s1_vld;

  assign cmp_hit = |way_hit;

  // Way 0 wins if both somehow hit
  assign cmp_hit_way = ~way_hit[0] & way_hit[1];

  //====================
  // Refill candidate
  //====================

  // Any empty way
  assign cmp_inv_found = ~&way_vld;

  // Lowest empty way is way 1 only when way 0 is valid
  assign cmp_inv_way = way_vld[0];

endmodule

/* hw/tag_lookup_result.sv */
// Lookup response register
`timescale 1ns/1ps

module tag_lookup_result (
  input  logic forever_cpuclk,
  input  logic rst_n,
  input  logic cmp_vld,
  input  logic cmp_hit,
  input  logic cmp_hit_way,
  input  logic cmp_inv_found,
  input  logic cmp_inv_way,
  output logic rsp_vld,
  output logic rsp_hit,
  output logic rsp_hit_way,
  output logic rsp_victim_way
);

  logic repl_ptr;
  logic repl_adv;
  logic victim_way;

  //====================
  // Victim select
  //====================

  // Miss with both ways valid moves the pointer
  assign repl_adv = cmp_vld & ~cmp_hit & ~cmp_inv_found;

  // Hit way, then empty way, then pointer
  always_comb begin
    if (cmp_hit) begin
      victim_way = cmp_hit_way;
    end else if (cmp_inv_found) begin
      victim_way = cmp_inv_way;
    end else begin
      victim_way = repl_ptr;
    end
  end

  //====================
  // Control regs
  //====================

  // One global pointer shared by all sets
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld  <= 1'b0;
      repl_ptr <= 1'b0;
    end else begin
      rsp_vld <= cmp_vld;
      if (repl_adv) begin
        repl_ptr <= ~repl_ptr;
      end
    end
  end

  //====================
  // Response payload
  //====================

  // Loaded only with a lookup
  always_ff @(posedge forever_cpuclk) begin
    if (cmp_vld) begin
      rsp_hit        <= cmp_hit;
      rsp_hit_way    <= cmp_hit_way;
      rsp_victim_way <= victim_way;
    end
  end

endmodule

/* hw/dcache_tag_top.sv */
// Data cache tag top level
`timescale 1ns/1ps

module dcache_tag_top import dcache_tag_pkg::*; (
  input  logic                forever_cpuclk,
  input  logic                rst_n,
  input  logic                icg_en,
  input  logic                scan_en,
  input  logic                req_vld,
  input  tag_op_e             req_op,
  input  logic [PA_W-1:0]     req_addr,
  input  logic [NUM_WAYS-1:0] req_way_mask,
  output logic                rsp_vld,
  output logic                rsp_hit,
  output logic                rsp_hit_way,
  output logic                rsp_victim_way
);

  // Decode to tag SRAM
  logic                tag_sel_b;
  logic                tag_gwen_b;
  logic [NUM_WAYS-1:0] tag_wen_b;
  logic [INDEX_W-1:0]  tag_idx;
  logic [LINE_W-1:0]   tag_din;
  logic                tag_gateclk_en;
  logic [LINE_W-1:0]   tag_dout;

  // First stage lookup
  logic                s1_vld;
  logic [TAG_W-1:0]    s1_tag;

  // Compare results
  logic                cmp_vld;
  logic                cmp_hit;
  logic                cmp_hit_way;
  logic                cmp_inv_found;
  logic                cmp_inv_way;

  //====================
  // Request decode
  //====================
  tag_req_decode x_tag_req_decode (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .req_vld        (req_vld),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_way_mask   (req_way_mask),
    .tag_sel_b      (tag_sel_b),
    .tag_gwen_b     (tag_gwen_b),
    .tag_wen_b      (tag_wen_b),
    .tag_idx        (tag_idx),
    .tag_din        (tag_din),
    .tag_gateclk_en (tag_gateclk_en),
    .s1_vld         (s1_vld),
    .s1_tag         (s1_tag)
  );

  //====================
  // Tag array
  //====================
  dcache_tag_array x_dcache_tag_array (
    .forever_cpuclk (forever_cpuclk),
    .scan_en        (scan_en),
    .icg_en         (icg_en),
    .tag_gateclk_en (tag_gateclk_en),
    .tag_sel_b      (tag_sel_b),
    .tag_gwen_b     (tag_gwen_b),
    .tag_wen_b      (tag_wen_b),
    .tag_idx        (tag_idx),
    .tag_din        (tag_din),
    .tag_dout       (tag_dout)
  );

  //====================
  // Compare and result
  //====================
  tag_hit_compare x_tag_hit_compare (
    .s1_vld        (s1_vld),
    .s1_tag        (s1_tag),
    .tag_dout      (tag_dout),
    .cmp_vld       (cmp_vld),
    .cmp_hit       (cmp_hit),
    .cmp_hit_way   (cmp_hit_way),
    .cmp_inv_found (cmp_inv_found),
    .cmp_inv_way   (cmp_inv_way)
  );

  tag_lookup_result x_tag_lookup_result (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .cmp_vld        (cmp_vld),
    .cmp_hit        (cmp_hit),
    .cmp_hit_way    (cmp_hit_way),
    .cmp_inv_found  (cmp_inv_found),
    .cmp_inv_way    (cmp_inv_way),
    .rsp_vld        (rsp_vld),
    .rsp_hit        (rsp_hit),
    .rsp_hit_way    (rsp_hit_way),
    .rsp_victim_way (rsp_victim_way)
  );

endmodule

/* tb/tb_dcache_tag_top.sv */
// Data cache tag testbench
`timescale 1ns/1ps

module tb_dcache_tag_top import dcache_tag_pkg::*; ();

  //====================
  // Test sizes
  //====================
  localparam int CLK_PERIOD  = 20;
  localparam int NUM_SETS    = 1 << INDEX_W;
  localparam int WAY_IDX_W   = $clog2(NUM_WAYS);
  localparam int T1_LOOKUPS  = 64;
  localparam int T2_ROUNDS   = 48;
  localparam int T3_SETS     = 8;
  localparam int T3_IDX      = 256;
  localparam int T4_MIX      = 400;
  localparam int T5_MIX      = 200;
  // Fill, fill, two misses per set, plus two invalidate and lookup pairs
  localparam int TOTAL_REQ   = NUM_SETS + T1_LOOKUPS + 3 * T2_ROUNDS + 4 * T3_SETS + 4
                               + T4_MIX + 2 * T5_MIX;
  localparam int CYCLE_LIMIT = TOTAL_REQ + 600;

  // DUT ports
  logic                forever_cpuclk;
  logic                rst_n;
  logic                icg_en;
  logic                scan_en;
  logic                req_vld;
  tag_op_e             req_op;
  logic [PA_W-1:0]     req_addr;
  logic [NUM_WAYS-1:0] req_way_mask;
  logic                rsp_vld;
  logic                rsp_hit;
  logic                rsp_hit_way;
  logic                rsp_victim_way;

  // Run state
  integer seed;
  int     cycle_cnt = 0;
  int     err_cnt = 0;
  int     lookup_cnt = 0;
  int     test_err_base;
  int     test_lookup_base;

  // Reference tag model with one global pointer
  logic             mdl_vld [NUM_SETS][NUM_WAYS];
  logic [TAG_W-1:0] mdl_tag [NUM_SETS][NUM_WAYS];
  logic             mdl_ptr;

  // Expected responses in request order
  int               exp_due_q [$];
  logic             exp_hit_q [$];
  logic             exp_way_q [$];
  logic             exp_victim_q [$];

  dcache_tag_top u_dcache_tag_top (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .icg_en         (icg_en),
    .scan_en        (scan_en),
    .req_vld        (req_vld),
    .req_op         (req_op),
    .req_addr       (req_addr),
    .req_way_mask   (req_way_mask),
    .rsp_vld        (rsp_vld),
    .rsp_hit        (rsp_hit),
    .rsp_hit_way    (rsp_hit_way),
    .rsp_victim_way (rsp_victim_way)
  );

  //====================
  // Clock and timeout
  //====================
  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) forever_cpuclk = ~forever_cpuclk;
    end
  end

  always @(posedge forever_cpuclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, responses still outstanding", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  //====================
  // Compare tasks
  //====================
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_way(input string name, input logic [WAY_IDX_W-1:0] got,
                           input logic [WAY_IDX_W-1:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s got way %0d expected way %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic pop_expected();
    void'(exp_due_q.pop_front());
    void'(exp_hit_q.pop_front());
    void'(exp_way_q.pop_front());
    void'(exp_victim_q.pop_front());
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge forever_cpuclk) begin
    if (rsp_vld === 1'b1) begin
      if (exp_due_q.size() == 0 || exp_due_q[0] != cycle_cnt) begin
        $display("Unexpected rsp_vld at %0t with no lookup due in this cycle", $time);
        err_cnt++;
      end else begin
        check_bit("rsp_hit", rsp_hit, exp_hit_q[0]);
        // Hit way only defined on a hit
        if (exp_hit_q[0]) begin
          check_way("rsp_hit_way", rsp_hit_way, exp_way_q[0]);
        end
        check_way("rsp_victim_way", rsp_victim_way, exp_victim_q[0]);
        pop_expected();
      end
    end else if (exp_due_q.size() != 0 && exp_due_q[0] <= cycle_cnt) begin
      $display("Missing rsp_vld at %0t for a lookup due in cycle %0d", $time, exp_due_q[0]);
      err_cnt++;
      pop_expected();
    end
  end

  //====================
  // Reference model
  //====================
  task automatic model_req(input tag_op_e op, input logic [PA_W-1:0] addr,
                           input logic [NUM_WAYS-1:0] mask);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    logic               hit_way;
    logic               victim;
    idx     = addr[OFFSET_W +: INDEX_W];
    tag     = addr[PA_W-1 -: TAG_W];
    hit     = 1'b0;
    hit_way = 1'b0;
    if (op == OP_FILL || op == OP_INVAL) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (mask[w]) begin
          mdl_vld[idx][w] = (op == OP_FILL);
          mdl_tag[idx][w] = (op == OP_FILL) ? tag : '0;
        end
      end
    end else begin
      // Walk down so way 0 wins a double hit
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (mdl_vld[idx][w] && mdl_tag[idx][w] == tag) begin
          hit     = 1'b1;
          hit_way = 1'(w);
        end
      end
      if (hit) begin
        victim = hit_way;
      end else if (!mdl_vld[idx][0]) begin
        victim = 1'b0;
      end else if (!mdl_vld[idx][1]) begin
        victim = 1'b1;
      end else begin
        victim  = mdl_ptr;
        mdl_ptr = ~mdl_ptr;
      end
      // Sampled at the next rising edge and answered one edge later
      exp_due_q.push_back(cycle_cnt + 2);
      exp_hit_q.push_back(hit);
      exp_way_q.push_back(hit_way);
      exp_victim_q.push_back(victim);
      lookup_cnt++;
    end
  endtask

  //====================
  // Stimulus helpers
  //====================
  function automatic logic [PA_W-1:0] make_addr(input logic [TAG_W-1:0] tag,
                                                input logic [INDEX_W-1:0] idx,
                                                input logic [OFFSET_W-1:0] off);
    return {tag, idx, off};
  endfunction

  task automatic send_req(input tag_op_e op, input logic [PA_W-1:0] addr,
                          input logic [NUM_WAYS-1:0] mask);
    @(negedge forever_cpuclk);
    req_vld      = 1'b1;
    req_op       = op;
    req_addr     = addr;
    req_way_mask = mask;
    model_req(op, addr, mask);
  endtask

  task automatic idle_cycle();
    @(negedge forever_cpuclk);
    req_vld = 1'b0;
  endtask

  // Small tag and index range keeps hits frequent
  task automatic run_mix(input int n, input logic [TAG_W-1:0] tag_base);
    logic [31:0] r;
    tag_op_e     op;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      if (r[15:13] == 3'd0) begin
        idle_cycle();
      end else begin
        case (r[1:0])
          2'd1:    op = OP_FILL;
          2'd2:    op = OP_INVAL;
          default: op = OP_LOOKUP;
        endcase
        send_req(op, make_addr({tag_base[TAG_W-1:2], r[8:7]}, INDEX_W'(r[6:4]), r[14:9]),
                 r[3:2]);
      end
    end
  endtask

  task automatic start_test();
    test_err_base    = err_cnt;
    test_lookup_base = lookup_cnt;
  endtask

  // Let every outstanding response land before reporting
  task automatic end_test(input string name);
    idle_cycle();
    while (exp_due_q.size() != 0) begin
      @(negedge forever_cpuclk);
    end
    @(negedge forever_cpuclk);
    $display("test %s: %s, %0d lookups, %0d errors", name,
             (err_cnt == test_err_base) ? "ok" : "mismatch",
             lookup_cnt - test_lookup_base, err_cnt - test_err_base);
  endtask

  //====================
  // Main sequence
  //====================
  initial begin
    logic [31:0]         r;
    logic [31:0]         r2;
    logic [PA_W-1:0]     addr;
    logic [NUM_WAYS-1:0] mask;
    logic [TAG_W-3:0]    tag_hi;
    seed         = 32'h3e3d8b80;
    rst_n        = 1'b0;
    icg_en       = 1'b1;
    scan_en      = 1'b0;
    req_vld      = 1'b0;
    req_op       = OP_LOOKUP;
    req_addr     = '0;
    req_way_mask = '0;
    mdl_ptr      = 1'b0;
    repeat (3) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst_n = 1'b1;

    // Clear every set before the first lookup
    start_test();
    for (int s = 0; s < NUM_SETS; s++) begin
      r = $random(seed);
      send_req(OP_INVAL, make_addr(r[TAG_W-1:0], INDEX_W'(s), r[31:26]), 2'b11);
    end
    for (int i = 0; i < T1_LOOKUPS; i++) begin
      r  = $random(seed);
      r2 = $random(seed);
      send_req(OP_LOOKUP, make_addr(r2[TAG_W-1:0], r[INDEX_W-1:0], r[31:26]), '0);
    end
    end_test("1 invalidate all then lookup");

    // Lookup right behind the fill, then same index with another tag
    start_test();
    for (int i = 0; i < T2_ROUNDS; i++) begin
      r    = $random(seed);
      r2   = $random(seed);
      mask = (r2[1:0] == 2'b00) ? 2'b01 : r2[1:0];
      addr = make_addr(r[TAG_W-1:0], r2[10:2], r2[16:11]);
      send_req(OP_FILL, addr, mask);
      send_req(OP_LOOKUP, addr, '0);
      addr[PA_W-1] = ~addr[PA_W-1];
      send_req(OP_LOOKUP, addr, '0);
    end
    end_test("2 fill then hit");

    // Full sets, then misses walk the global pointer
    start_test();
    r      = $random(seed);
    tag_hi = r[TAG_W-1:2];
    for (int s = 0; s < T3_SETS; s++) begin
      send_req(OP_FILL, make_addr({tag_hi, 2'b00}, INDEX_W'(T3_IDX + s), '0), 2'b01);
      send_req(OP_FILL, make_addr({tag_hi, 2'b01}, INDEX_W'(T3_IDX + s), '0), 2'b10);
    end
    for (int k = 0; k < 2; k++) begin
      for (int s = 0; s < T3_SETS; s++) begin
        send_req(OP_LOOKUP, make_addr({tag_hi, 2'b10}, INDEX_W'(T3_IDX + s), '0), '0);
      end
    end
    // One hole per set and the victim must point at it
    send_req(OP_INVAL, make_addr({tag_hi, 2'b00}, INDEX_W'(T3_IDX), '0), 2'b10);
    send_req(OP_LOOKUP, make_addr({tag_hi, 2'b10}, INDEX_W'(T3_IDX), '0), '0);
    send_req(OP_INVAL, make_addr({tag_hi, 2'b00}, INDEX_W'(T3_IDX + 1), '0), 2'b01);
    send_req(OP_LOOKUP, make_addr({tag_hi, 2'b10}, INDEX_W'(T3_IDX + 1), '0), '0);
    end_test("3 replacement order");

    start_test();
    r = $random(seed);
    run_mix(T4_MIX, r[TAG_W-1:0]);
    end_test("4 back to back random mix");

    // Free running tag clock
    start_test();
    icg_en = 1'b0;
    r      = $random(seed);
    run_mix(T5_MIX, r[TAG_W-1:0]);
    end_test("5a random mix with gating off");

    // Tag clock only on access cycles
    start_test();
    icg_en = 1'b1;
    r      = $random(seed);
    run_mix(T5_MIX, r[TAG_W-1:0]);
    end_test("5b random mix with gating on");

    $display("summary: %0d lookups checked, %0d errors", lookup_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* dcache_tag_top.f */
common/dcache_tag_pkg.sv
hw/tag_array/gated_clk_cell.sv
hw/tag_array/spsram_512x52.sv
hw/tag_array/dcache_tag_array.sv
hw/tag_req_decode.sv
hw/tag_hit_compare.sv
hw/tag_lookup_result.sv
hw/dcache_tag_top.sv
tb/tb_dcache_tag_top.sv

/* Makefile */
# Verilator build and run for the data cache tag testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache_tag_top
FILELIST  ?= dcache_tag_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= sim passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

# Output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
